// File: dv/tb_ps2_keyboard.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_defines.svh"

module tb_ps2_keyboard;

    localparam int DEPTH   = 2 ** `PS2_FIFO_AW;
    localparam int TIMEOUT = 2000;  // Cycles per wait for an event
    localparam int NVEC    = 7;

    typedef struct packed {
        logic [1:0] nbytes;     // 2 when b0 is a prefix
        logic [7:0] b0;
        logic [7:0] b1;
        logic       bad;        // Wrong parity on the last frame
        logic [7:0] scan;
        logic [7:0] ascii;
        logic       released;
        logic       has_event;
    } vec_t;

    logic                clk;
    logic                rst_n;
    logic                ps2_clk;
    logic                ps2_data;
    logic                key_ready;
    logic                key_valid;
    logic                overflow;
    logic                frame_error;
    ps2_pkg::key_event_t key;

    ps2_pkg::key_event_t got [$];  // Events accepted by the host side
    vec_t                vecs [NVEC];
    logic [15:0]         lfsr;
    logic                test_fail;
    int                  n_tests;
    int                  n_errors;

    // Set 2 make codes, A to Z then 0 to 9
    logic [7:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
        8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    logic [7:0] digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
        8'h3D, 8'h3E, 8'h46};

    ps2_keyboard_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_ready   (key_ready),
        .key_valid   (key_valid),
        .key         (key),
        .overflow    (overflow),
        .frame_error (frame_error)
    );

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (key_valid && key_ready)
            got.push_back(key);  // Transfer on the next rising edge
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] key_code(input int idx);
        return (idx < 26) ? letter_codes[idx] : digit_codes[idx - 26];
    endfunction

    function automatic logic [7:0] ascii_of(input logic [7:0] code);
        logic [7:0] ch;
        ch = 8'h00;
        for (int i = 0; i < 26; i++)
            if (letter_codes[i] == code)
                ch = 8'h41 + 8'(i);
        for (int i = 0; i < 10; i++)
            if (digit_codes[i] == code)
                ch = 8'h30 + 8'(i);
        return ch;
    endfunction

    function automatic vec_t make_vec(input logic [1:0] nbytes, input logic [7:0] b0,
                                      input logic [7:0] b1, input logic bad,
                                      input logic released, input logic has_event);
        logic [7:0] scan;
        scan = (nbytes == 2'd2) ? b1 : b0;
        return '{nbytes, b0, b1, bad, scan, ascii_of(scan), released, has_event};
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    // One device-to-host frame, PS/2 half period of 4 clocks
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [`PS2_FRAME_BITS-1:0] frame;
        frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            ps2_data = frame[i];  // Changes while ps2_clk is high
            tick(4);
            ps2_clk = 1'b0;
            tick(4);
            ps2_clk = 1'b1;
        end
        tick(4);
        ps2_data = 1'b1;
    endtask

    task automatic wait_event(output logic ok, output ps2_pkg::key_event_t ev);
        int n;
        n = 0;
        while (got.size() == 0 && n < TIMEOUT) begin
            tick(1);
            n++;
        end
        ok = (got.size() != 0);
        ev = '0;
        if (ok) begin
            ev = got.pop_front();
        end else begin
            $display("timeout waiting for key event at %0t ns", $time);
            test_fail = 1'b1;
        end
    endtask

    task automatic compare_event(input ps2_pkg::key_event_t ev, input logic [7:0] scan,
                                 input logic [7:0] ascii, input logic released);
        if (ev.scan != scan) begin
            $display("error at %0t ns: scan %h, expected %h", $time, ev.scan, scan);
            test_fail = 1'b1;
        end
        if (ev.ascii != ascii) begin
            $display("error at %0t ns: ascii %h for scan %h, expected %h",
                     $time, ev.ascii, scan, ascii);
            test_fail = 1'b1;
        end
        if (ev.released != released) begin
            $display("error at %0t ns: released %b for scan %h, expected %b",
                     $time, ev.released, scan, released);
            test_fail = 1'b1;
        end
    endtask

    task automatic check_no_more(input string what);
        tick(40);
        if (got.size() != 0) begin
            $display("unexpected key event with scan %h after %s", got[0].scan, what);
            test_fail = 1'b1;
            got.delete();
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (test_fail) begin
            n_errors++;
            $display("test %0d %s: FAIL", n_tests, name);
        end else begin
            $display("test %0d %s: ok", n_tests, name);
        end
        test_fail = 1'b0;
    endtask

    initial begin
        logic                ok;
        ps2_pkg::key_event_t ev;
        int                  idx;
        logic [7:0]          sent [$];
        clk       = 1'b0;
        rst_n     = 1'b0;
        ps2_clk   = 1'b1;  // Idle PS/2 bus
        ps2_data  = 1'b1;
        key_ready = 1'b1;
        lfsr      = 16'd45;
        test_fail = 1'b0;
        n_tests   = 0;
        n_errors  = 0;
        vecs[0] = make_vec(2'd1, 8'h1C, 8'h00, 1'b0, 1'b0, 1'b1);  // A
        vecs[1] = make_vec(2'd1, 8'h16, 8'h00, 1'b0, 1'b0, 1'b1);  // 1
        vecs[2] = make_vec(2'd2, ps2_pkg::BREAK_PREFIX, 8'h1C, 1'b0, 1'b1, 1'b1);
        vecs[3] = make_vec(2'd2, ps2_pkg::BREAK_PREFIX, 8'h45, 1'b0, 1'b1, 1'b1);
        vecs[4] = make_vec(2'd1, 8'h05, 8'h00, 1'b0, 1'b0, 1'b1);  // Unmapped
        vecs[5] = make_vec(2'd1, 8'h2B, 8'h00, 1'b1, 1'b0, 1'b0);  // Bad parity
        vecs[6] = make_vec(2'd1, 8'h33, 8'h00, 1'b0, 1'b0, 1'b1);
        tick(4);
        rst_n = 1'b1;
        tick(2);

        if (key_valid !== 1'b0 || overflow !== 1'b0 || frame_error !== 1'b0) begin
            $display("error at %0t ns: outputs not clear after reset", $time);
            test_fail = 1'b1;
        end
        end_test("reset");

        for (int t = 0; t < NVEC; t++) begin
            send_frame(vecs[t].b0, vecs[t].bad && vecs[t].nbytes == 2'd1);
            if (vecs[t].nbytes == 2'd2)
                send_frame(vecs[t].b1, vecs[t].bad);
            if (vecs[t].has_event) begin
                wait_event(ok, ev);
                if (ok)
                    compare_event(ev, vecs[t].scan, vecs[t].ascii, vecs[t].released);
            end
            check_no_more($sformatf("table entry %0d", t));
            end_test($sformatf("table entry %0d", t));
        end

        if (frame_error !== 1'b1 || overflow !== 1'b0) begin
            $display("error at %0t ns: frame_error %b overflow %b, expected 1 and 0",
                     $time, frame_error, overflow);
            test_fail = 1'b1;
        end
        end_test("error flags");

        // Decoder holds one event, FIFO takes DEPTH more, the last is dropped
        key_ready = 1'b0;
        for (int i = 0; i < DEPTH + 2; i++)
            send_frame(key_code(i), 1'b0);
        tick(20);
        if (overflow !== 1'b1) begin
            $display("error at %0t ns: overflow %b, expected 1", $time, overflow);
            test_fail = 1'b1;
        end
        key_ready = 1'b1;
        for (int i = 0; i < DEPTH + 1; i++) begin
            wait_event(ok, ev);
            if (ok)
                compare_event(ev, key_code(i), ascii_of(key_code(i)), 1'b0);
        end
        check_no_more("overflow burst");
        end_test("overflow");

        for (int i = 0; i < 20; i++) begin
            take_bits(6, idx);
            sent.push_back(key_code(idx % 36));
            send_frame(sent[i], 1'b0);
        end
        for (int i = 0; i < 20; i++) begin
            wait_event(ok, ev);
            if (ok)
                compare_event(ev, sent[i], ascii_of(sent[i]), 1'b0);
        end
        check_no_more("random keys");
        end_test("random keys");

        $display("%0d tests run, %0d failed", n_tests, n_errors);
        if (n_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/ps2_pkg.sv
hdl/ps2_frame_rx.sv
hdl/scan_fifo.sv
hdl/key_decoder.sv
hdl/ps2_keyboard_top.sv
dv/tb_ps2_keyboard.sv

// File: hdl/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                not_empty,
    input  logic [7:0]          rd_data,
    input  logic                key_ready,
    output logic                pop,
    output logic                key_valid,
    output ps2_pkg::key_event_t key
);

    ps2_pkg::dec_state_t state;
    logic [7:0] byte_q;   // Byte taken from the FIFO head
    logic       pending;  // F0 seen, next event is a release
    logic       is_break;

    // Set 2 make codes to upper case ASCII
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        logic [7:0] ch;
        case (code)
            8'h1C: ch = 8'h41;  // A
            8'h32: ch = 8'h42;
            8'h21: ch = 8'h43;
            8'h23: ch = 8'h44;
            8'h24: ch = 8'h45;
            8'h2B: ch = 8'h46;
            8'h34: ch = 8'h47;
            8'h33: ch = 8'h48;
            8'h43: ch = 8'h49;
            8'h3B: ch = 8'h4A;
            8'h42: ch = 8'h4B;
            8'h4B: ch = 8'h4C;
            8'h3A: ch = 8'h4D;
            8'h31: ch = 8'h4E;
            8'h44: ch = 8'h4F;
            8'h4D: ch = 8'h50;
            8'h15: ch = 8'h51;
            8'h2D: ch = 8'h52;
            8'h1B: ch = 8'h53;
            8'h2C: ch = 8'h54;
            8'h3C: ch = 8'h55;
            8'h2A: ch = 8'h56;
            8'h1D: ch = 8'h57;
            8'h22: ch = 8'h58;
            8'h35: ch = 8'h59;
            8'h1A: ch = 8'h5A;  // Z
            8'h45: ch = 8'h30;  // 0
            8'h16: ch = 8'h31;
            8'h1E: ch = 8'h32;
            8'h26: ch = 8'h33;
            8'h25: ch = 8'h34;
            8'h2E: ch = 8'h35;
            8'h36: ch = 8'h36;
            8'h3D: ch = 8'h37;
            8'h3E: ch = 8'h38;
            8'h46: ch = 8'h39;  // 9
            default: ch = 8'h00;  // E0 and other keys land here
        endcase
        return ch;
    endfunction

    assign pop       = (state == ps2_pkg::dec_fetch) && not_empty;
    assign key_valid = (state == ps2_pkg::dec_hold);
    assign is_break  = (byte_q == ps2_pkg::BREAK_PREFIX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ps2_pkg::dec_fetch;
            pending <= 1'b0;
        end else begin
            case (state)
                ps2_pkg::dec_fetch: begin
                    if (not_empty)
                        state <= ps2_pkg::dec_wait_data;
                end
                ps2_pkg::dec_wait_data: begin
                    if (is_break) begin
                        pending <= 1'b1;  // Prefix makes no event
                        state   <= ps2_pkg::dec_fetch;
                    end else begin
                        pending <= 1'b0;
                        state   <= ps2_pkg::dec_hold;
                    end
                end
                ps2_pkg::dec_hold: begin
                    if (key_ready)
                        state <= ps2_pkg::dec_fetch;
                end
                default: state <= ps2_pkg::dec_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            byte_q <= rd_data;  // Head moves on this edge
        if (state == ps2_pkg::dec_wait_data && !is_break) begin
            key.scan     <= byte_q;
            key.ascii    <= scan_to_ascii(byte_q);
            key.released <= pending;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ps2_defines.svh
`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

// Address width of the scan byte FIFO
// Depth is 2**PS2_FIFO_AW entries
`define PS2_FIFO_AW 3

// Bits in one device-to-host PS/2 frame
// start + 8 data + odd parity + stop
`define PS2_FRAME_BITS 11

`endif

// File: hdl/ps2_frame_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_defines.svh"

module ps2_frame_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       frame_error
);

    localparam int DATA_BITS = `PS2_FRAME_BITS - 3;

    logic [1:0] clk_sync;   // 2-flop synchronizer, ps2_clk
    logic [1:0] data_sync;  // 2-flop synchronizer, ps2_data
    logic       clk_prev;   // Edge register
    logic       ps2_fall;
    logic       ps2_data_s;

    ps2_pkg::rx_state_t state;
    logic [3:0] bit_cnt;
    logic [7:0] shift_q;
    logic       parity_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;  // Idle bus is high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign ps2_fall   = clk_prev & ~clk_sync[1];
    assign ps2_data_s = data_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ps2_pkg::rx_idle;
            bit_cnt     <= 4'd0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (ps2_fall) begin
                case (state)
                    ps2_pkg::rx_idle: begin
                        bit_cnt <= 4'd0;
                        if (!ps2_data_s)        // High start bit is noise
                            state <= ps2_pkg::rx_data;
                    end
                    ps2_pkg::rx_data: begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'(DATA_BITS - 1))
                            state <= ps2_pkg::rx_parity;
                    end
                    ps2_pkg::rx_parity: begin
                        state <= ps2_pkg::rx_stop;
                    end
                    default: begin
                        // Stop bit must be 1, data plus parity must be odd
                        if (ps2_data_s && (^{shift_q, parity_q}))
                            byte_valid <= 1'b1;
                        else
                            frame_error <= 1'b1;  // Sticky until reset
                        state <= ps2_pkg::rx_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ps2_fall && state == ps2_pkg::rx_data)
            shift_q <= {ps2_data_s, shift_q[7:1]};  // LSB first
        if (ps2_fall && state == ps2_pkg::rx_parity)
            parity_q <= ps2_data_s;
    end

    assign byte_data = shift_q;

endmodule

`default_nettype wire

// File: hdl/ps2_keyboard_top.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                key_ready,
    output logic                key_valid,
    output ps2_pkg::key_event_t key,
    output logic                overflow,
    output logic                frame_error
);

    logic       byte_valid;
    logic [7:0] byte_data;
    logic       fifo_not_empty;
    logic [7:0] fifo_rd_data;
    logic       fifo_pop;

    ps2_frame_rx u_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_error (frame_error)
    );

    // No back-pressure toward the receiver, full FIFO drops
    scan_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (byte_valid),
        .wr_data   (byte_data),
        .pop       (fifo_pop),
        .rd_data   (fifo_rd_data),
        .not_empty (fifo_not_empty),
        .overflow  (overflow)
    );

    key_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .not_empty (fifo_not_empty),
        .rd_data   (fifo_rd_data),
        .key_ready (key_ready),
        .pop       (fifo_pop),
        .key_valid (key_valid),
        .key       (key)
    );

endmodule

`default_nettype wire

// File: hdl/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // Frame receiver states
    typedef enum logic [1:0] {
        rx_idle   = 2'd0,  // Waiting for start bit
        rx_data   = 2'd1,  // Shifting in data bits
        rx_parity = 2'd2,  // Parity bit next
        rx_stop   = 2'd3   // Stop bit next, frame check
    } rx_state_t;

    // Key decoder states
    typedef enum logic [1:0] {
        dec_fetch     = 2'd0,  // Pop head byte when available
        dec_wait_data = 2'd1,  // Translate captured byte
        dec_hold      = 2'd2   // Event presented to host
    } dec_state_t;

    // One key event as seen by the host
    typedef struct packed {
        logic [7:0] scan;      // Raw set 2 scan code
        logic [7:0] ascii;     // Upper case ASCII, 0 if unmapped
        logic       released;  // Key released after F0
    } key_event_t;

    // Break code prefix
    localparam logic [7:0] BREAK_PREFIX = 8'hF0;

endpackage

`default_nettype wire

// File: hdl/scan_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_defines.svh"

module scan_fifo #(
    parameter int AW = `PS2_FIFO_AW
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_valid,
    input  logic [7:0] wr_data,
    input  logic       pop,
    output logic [7:0] rd_data,
    output logic       not_empty,
    output logic       overflow
);

    localparam int DEPTH = 2 ** AW;

    logic [7:0] mem [DEPTH];
    logic [AW:0] wr_ptr;  // Extra MSB tells full from empty
    logic [AW:0] rd_ptr;
    logic        full;

    assign full      = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign not_empty = (wr_ptr != rd_ptr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_valid) begin
                if (full)
                    overflow <= 1'b1;  // Byte dropped, flag sticks
                else
                    wr_ptr <= wr_ptr + (AW+1)'(1);
            end
            if (pop && not_empty)
                rd_ptr <= rd_ptr + (AW+1)'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && !full)
            mem[wr_ptr[AW-1:0]] <= wr_data;
    end

    // Head entry always visible
    assign rd_data = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the PS/2 keyboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    -f filelist.f --top-module tb_ps2_keyboard -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    exit 0
fi
exit 1
